// ==== Makefile ====
# Verilator build and run of the branch prediction unit testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_bpu -f flist.f -o Vtb_bpu

run: compile
	./obj_dir/Vtb_bpu > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bpu_bht.sv ====
/*
 * Direction table of 2-bit saturating counters indexed by PC bits 7..2.
 * The upper counter bit is returned one cycle after the lookup.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_bht import bpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        lookup_en_i,
	input  logic [31:0] lookup_pc_i,
	input  bht_wr_t     wr_i,
	output logic        taken_o
);

	logic [1:0]           cnt_q [BHT_DEPTH];
	logic [1:0]           cnt_cur;
	logic [1:0]           cnt_nxt;
	logic [BHT_IDX_W-1:0] rd_idx;

	assign rd_idx  = lookup_pc_i[BHT_IDX_W+1:2];
	assign cnt_cur = cnt_q[wr_i.idx];

	// Saturate at 0 and 3
	always_comb begin
		cnt_nxt = cnt_cur;
		if (wr_i.clear)
			cnt_nxt = 2'b01;
		else if (wr_i.taken && cnt_cur != 2'b11)
			cnt_nxt = cnt_cur + 2'b01;
		else if (!wr_i.taken && cnt_cur != 2'b00)
			cnt_nxt = cnt_cur - 2'b01;
	end

	always_ff @(posedge clk) begin
		if (wr_i.we)
			cnt_q[wr_i.idx] <= cnt_nxt;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			taken_o <= 1'b0;
		else
			taken_o <= lookup_en_i & cnt_q[rd_idx][1];
	end

endmodule

`default_nettype wire

// ==== bpu_bpf.sv ====
/*
 * Branch feedback. Resolves direction, target, link address and class of
 * the branch in execute, flags mispredictions and raises the training
 * requests. Purely combinational.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_bpf import bpu_pkg::*; (
	input  logic [31:0] res_pc_i,
	input  logic [31:0] rj_i,
	input  logic [31:0] rd_i,
	input  logic [31:0] csr_target_i,
	input  decode_info_t decode_i,
	input  predict_t    predict_i,
	input  logic        stall_i,
	input  logic        csr_flush_i,
	output update_t     update_o,
	output logic [31:0] pc_link_o
);

	branch_type_e br_type;
	logic [15:0]  off16;
	logic [4:0]   rj_idx;
	logic [4:0]   rd_idx;
	logic [31:0]  offs16;
	logic [31:0]  offs26;
	logic         taken;
	logic [31:0]  target;
	br_class_e    cls;
	logic         dir_miss;
	logic         tgt_miss;

	assign br_type = decode_i.branch_type;
	assign off16   = decode_i.inst[25:10];
	assign rj_idx  = decode_i.inst[9:5];
	assign rd_idx  = decode_i.inst[4:0];

	// Word offsets, sign extended
	assign offs16 = {{14{off16[15]}}, off16, 2'b00};
	assign offs26 = {{4{decode_i.inst[9]}}, decode_i.inst[9:0], off16, 2'b00};

	// --------------------
	// Direction
	// --------------------
	always_comb begin
		taken = 1'b0;
		if (br_type == BR_COND) begin
			case (decode_i.cmp_type)
				CMP_EQ:  taken = (rj_i == rd_i);
				CMP_NE:  taken = (rj_i != rd_i);
				CMP_LT:  taken = ($signed(rj_i) <  $signed(rd_i));
				CMP_GT:  taken = ($signed(rj_i) >  $signed(rd_i));
				CMP_LE:  taken = ($signed(rj_i) <= $signed(rd_i));
				CMP_GE:  taken = ($signed(rj_i) >= $signed(rd_i));
				CMP_LTU: taken = (rj_i < rd_i);
				CMP_GTU: taken = (rj_i > rd_i);
				default: taken = 1'b0;
			endcase
		end else if (br_type != BR_NONE) begin
			taken = 1'b1;
		end
	end

	// --------------------
	// Target and class
	// --------------------
	always_comb begin
		case (br_type)
			BR_IMM:  target = res_pc_i + offs26;
			BR_IND:  target = rj_i + offs16;
			BR_COND: target = taken ? res_pc_i + offs16 : res_pc_i + 32'd4;
			default: target = res_pc_i + 32'd4;
		endcase
	end

	// Call takes priority over the return form
	always_comb begin
		if (decode_i.link || (br_type == BR_IND && rd_idx == 5'd1))
			cls = CLS_CALL;
		else if (br_type == BR_IND && rj_idx == 5'd1 && off16 == '0)
			cls = CLS_RET;
		else if (br_type == BR_IMM || br_type == BR_IND)
			cls = CLS_ABS;
		else
			cls = CLS_PCREL;
	end

	assign pc_link_o = res_pc_i + 32'd4;

	// --------------------
	// Misprediction and training
	// --------------------
	assign dir_miss = (predict_i.taken != taken);
	assign tgt_miss = predict_i.taken & taken & (predict_i.npc != target[31:2]);

	always_comb begin
		update_o.flush     = (decode_i.valid & ~stall_i & (dir_miss | tgt_miss)) | csr_flush_i;
		update_o.br_taken  = taken;
		update_o.pc        = res_pc_i[31:2];
		update_o.br_target = csr_flush_i ? csr_target_i : target;
		update_o.br_class  = cls;
		update_o.btb_we    = decode_i.valid & taken;
		update_o.bht_we    = decode_i.valid & (br_type == BR_COND);
		update_o.ras_push  = decode_i.valid & taken & (cls == CLS_CALL);
		update_o.ras_pop   = decode_i.valid & (cls == CLS_RET);
	end

endmodule

`default_nettype wire

// ==== bpu_btb.sv ====
/*
 * Direct-mapped branch target buffer. Lookup result is registered and
 * valid the cycle after lookup_en_i; writes land at the same edge.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_btb import bpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        lookup_en_i,
	input  logic [31:0] lookup_pc_i,
	input  btb_wr_t     wr_i,
	output logic        hit_o,
	output waddr_t      target_o,
	output br_class_e   class_o
);

	logic                 valid_q  [BTB_DEPTH];
	logic [BTB_TAG_W-1:0] tag_q    [BTB_DEPTH];
	waddr_t               target_q [BTB_DEPTH];
	br_class_e            class_q  [BTB_DEPTH];

	logic [BTB_IDX_W-1:0] rd_idx;
	logic [BTB_TAG_W-1:0] rd_tag;

	// Index from PC bits 5..2, tag from the bits above
	assign rd_idx = lookup_pc_i[BTB_IDX_W+1:2];
	assign rd_tag = lookup_pc_i[BTB_IDX_W+BTB_TAG_W+1:BTB_IDX_W+2];

	always_ff @(posedge clk) begin
		if (wr_i.we) begin
			valid_q[wr_i.idx]  <= wr_i.valid;
			tag_q[wr_i.idx]    <= wr_i.tag;
			target_q[wr_i.idx] <= wr_i.target;
			class_q[wr_i.idx]  <= wr_i.cls;
		end
	end

	// --------------------
	// Registered lookup
	// --------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			hit_o <= 1'b0;
		else
			hit_o <= lookup_en_i && valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	end

	always_ff @(posedge clk) begin
		if (lookup_en_i) begin
			target_o <= target_q[rd_idx];
			class_o  <= class_q[rd_idx];
		end
	end

endmodule

`default_nettype wire

// ==== bpu_ctrl.sv ====
/*
 * Init/run control of the predictor. Sweeps both tables after reset,
 * raises ready, and passes training requests to the table write ports
 * only for resolves that commit.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_ctrl import bpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    resolve_valid_i,
	input  logic    stall_i,
	input  logic    csr_flush_i,
	input  logic    fetch_valid_i,
	input  update_t req_i,
	output logic    ready_o,
	output logic    lookup_en_o,
	output btb_wr_t btb_wr_o,
	output bht_wr_t bht_wr_o,
	output logic    ras_push_o,
	output logic    ras_pop_o
);

	ctrl_state_e            state_q;
	logic [INIT_CNT_W-1:0]  sweep_q;
	logic                   commit;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_INIT;
			sweep_q <= '0;
		end else if (state_q == ST_INIT) begin
			sweep_q <= sweep_q + 1'b1;
			if (sweep_q == INIT_CNT_W'(INIT_CYCLES - 1))
				state_q <= ST_RUN;
		end
	end

	assign ready_o     = (state_q == ST_RUN);
	assign lookup_en_o = ready_o & fetch_valid_i;
	assign commit      = ready_o & resolve_valid_i & ~stall_i & ~csr_flush_i;

	// --------------------
	// Table write ports
	// --------------------
	always_comb begin
		btb_wr_o   = '0;
		bht_wr_o   = '0;
		ras_push_o = 1'b0;
		ras_pop_o  = 1'b0;
		if (state_q == ST_INIT) begin
			// Invalidate entry and reset counter
			btb_wr_o.we    = 1'b1;
			btb_wr_o.idx   = sweep_q[BTB_IDX_W-1:0];
			bht_wr_o.we    = 1'b1;
			bht_wr_o.idx   = sweep_q[BHT_IDX_W-1:0];
			bht_wr_o.clear = 1'b1;
		end else if (commit) begin
			btb_wr_o.we     = req_i.btb_we;
			btb_wr_o.idx    = req_i.pc[BTB_IDX_W-1:0];
			btb_wr_o.tag    = req_i.pc[BTB_IDX_W +: BTB_TAG_W];
			btb_wr_o.valid  = 1'b1;
			btb_wr_o.target = req_i.br_target[31:2];
			btb_wr_o.cls    = req_i.br_class;
			bht_wr_o.we     = req_i.bht_we;
			bht_wr_o.idx    = req_i.pc[BHT_IDX_W-1:0];
			bht_wr_o.taken  = req_i.br_taken;
			ras_push_o      = req_i.ras_push;
			ras_pop_o       = req_i.ras_pop;
		end
	end

endmodule

`default_nettype wire

// ==== bpu_pkg.sv ====
/*
 * Shared sizes, encodings and bus structs of the branch prediction unit.
 * Imported by every RTL block and by the testbench.
 */
`default_nettype none

package bpu_pkg;

	// --------------------
	// Table geometry
	// --------------------
	localparam int BTB_IDX_W   = 4;
	localparam int BTB_TAG_W   = 10;
	localparam int BTB_DEPTH   = 2 ** BTB_IDX_W;
	localparam int BHT_IDX_W   = 6;
	localparam int BHT_DEPTH   = 2 ** BHT_IDX_W;
	localparam int RAS_DEPTH   = 8;
	localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);
	// Sweep long enough for the larger table
	localparam int INIT_CYCLES = 64;
	localparam int INIT_CNT_W  = $clog2(INIT_CYCLES);

	// Word address, PC bits 31..2
	typedef logic [29:0] waddr_t;

	// --------------------
	// Encodings
	// --------------------
	typedef enum logic [1:0] {BR_NONE, BR_IMM, BR_IND, BR_COND} branch_type_e;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GT, CMP_LE, CMP_GE, CMP_LTU, CMP_GTU
	} cmp_type_e;

	typedef enum logic [1:0] {CLS_PCREL, CLS_ABS, CLS_CALL, CLS_RET} br_class_e;

	typedef enum logic {ST_INIT, ST_RUN} ctrl_state_e;

	// --------------------
	// Buses
	// --------------------
	typedef struct packed {
		logic         valid;
		branch_type_e branch_type;
		cmp_type_e    cmp_type;
		logic         link;
		logic [25:0]  inst;   // off16 | rj | rd, off26 high part in 9..0
	} decode_info_t;

	typedef struct packed {
		logic   taken;
		waddr_t npc;
	} predict_t;

	typedef struct packed {
		logic        flush;
		logic        br_taken;
		waddr_t      pc;
		logic [31:0] br_target;
		br_class_e   br_class;
		logic        btb_we;
		logic        bht_we;
		logic        ras_push;
		logic        ras_pop;
	} update_t;

	typedef struct packed {
		logic                 we;
		logic [BTB_IDX_W-1:0] idx;
		logic [BTB_TAG_W-1:0] tag;
		logic                 valid;
		waddr_t               target;
		br_class_e            cls;
	} btb_wr_t;

	typedef struct packed {
		logic                 we;
		logic [BHT_IDX_W-1:0] idx;
		logic                 taken;
		logic                 clear;  // load weakly not-taken
	} bht_wr_t;

endpackage

`default_nettype wire

// ==== bpu_properties.sv ====
/*
 * Concurrent checks bound into the predictor top for the reset state,
 * flush gating under stall and the one-cycle prediction timing.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_properties import bpu_pkg::*; (
	input logic    clk,
	input logic    arst_n_i,
	input logic    ready_o,
	input logic    predict_valid_o,
	input logic    fetch_valid_i,
	input logic    stall_i,
	input logic    csr_flush_i,
	input update_t update_o
);

	// Tables still clearing right after release
	assert property (@(posedge clk) $rose(arst_n_i) |-> (!ready_o && !predict_valid_o))
		else $error("ready_o or predict_valid_o high in the cycle after reset");

	// Only a CSR flush may get through a stall
	assert property (@(posedge clk) disable iff (!arst_n_i)
		(stall_i && !csr_flush_i) |-> !update_o.flush)
		else $error("flush raised under stall without a CSR flush");

	assert property (@(posedge clk) disable iff (!arst_n_i)
		(ready_o && $past(ready_o)) |-> (predict_valid_o == $past(fetch_valid_i)))
		else $error("predict_valid_o does not follow fetch_valid_i by one cycle");

endmodule

bind bpu_top bpu_properties u_props (.*);

`default_nettype wire

// ==== bpu_ras.sv ====
/*
 * Circular return address stack. Pushed on resolved calls, popped on
 * resolved returns; overflow drops the oldest entry.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_ras import bpu_pkg::*; (
	input  logic   clk,
	input  logic   arst_n_i,
	input  logic   push_i,
	input  waddr_t push_addr_i,
	input  logic   pop_i,
	output waddr_t top_o
);

	waddr_t               stack_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] tos_q;
	logic [RAS_PTR_W-1:0] tos_inc;
	logic [RAS_PTR_W:0]   cnt_q;
	logic                 empty;
	logic                 full;

	assign tos_inc = tos_q + 1'b1;
	assign empty   = (cnt_q == '0);
	assign full    = (cnt_q == (RAS_PTR_W + 1)'(RAS_DEPTH));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tos_q <= '0;
			cnt_q <= '0;
		end else if (push_i && pop_i) begin
			// Top replaced in place
			if (empty)
				cnt_q <= (RAS_PTR_W + 1)'(1);
		end else if (push_i) begin
			tos_q <= tos_inc;
			if (!full)
				cnt_q <= cnt_q + 1'b1;
		end else if (pop_i && !empty) begin
			tos_q <= tos_q - 1'b1;
			cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i)
			stack_q[pop_i ? tos_q : tos_inc] <= push_addr_i;
	end

	assign top_o = empty ? '0 : stack_q[tos_q];

endmodule

`default_nettype wire

// ==== bpu_testdata.txt ====
# RESOLVE pc rj rd valid btype cmp link inst pred_taken pred_npc stall csr_flush csr_target
#   then expected flush taken br_target class train(btb bht push pop) pc_link
# FETCH pc, then expected taken npc
FETCH 00001000 0 00001004
RESOLVE 00001000 00000005 00000005 1 3 0 0 0004085 0 00000000 0 0 00000000 1 1 00001040 0 1100 00001004
RESOLVE 00001000 00000005 00000005 1 3 0 0 0004085 1 00001040 0 0 00000000 0 1 00001040 0 1100 00001004
FETCH 00001000 1 00001040
RESOLVE 00001000 00000005 00000006 1 3 0 0 0004085 1 00001040 0 0 00000000 1 0 00001004 0 0100 00001004
RESOLVE 00001000 00000005 00000006 1 3 0 0 0004085 0 00000000 0 0 00000000 0 0 00001004 0 0100 00001004
FETCH 00001000 0 00001004
RESOLVE 00002008 00005554 00000000 1 2 0 0 0000020 0 00000000 0 0 00000000 1 1 00005554 3 1001 0000200c
RESOLVE 00003010 00000000 00000000 1 1 0 1 0040000 1 00003410 0 0 00000000 0 1 00003410 2 1010 00003014
FETCH 00002008 1 00003014
RESOLVE 00003020 00008000 00000000 1 2 0 0 00020e1 1 00008000 0 0 00000000 1 1 00008020 2 1010 00003024
FETCH 00002008 1 00003024
RESOLVE 00002008 00003024 00000000 1 2 0 0 0000020 1 00003024 0 0 00000000 0 1 00003024 3 1001 0000200c
FETCH 00002008 1 00003014
RESOLVE 00000104 80000000 80000000 1 3 0 0 3ffe085 0 00000000 0 0 00000000 1 1 000000e4 0 1100 00000108
RESOLVE 00000104 80000000 80000000 1 3 1 0 3ffe085 0 00000000 0 0 00000000 0 0 00000108 0 0100 00000108
RESOLVE 00000104 80000000 7fffffff 1 3 2 0 3ffe085 0 00000000 0 0 00000000 1 1 000000e4 0 1100 00000108
RESOLVE 00000104 80000000 7fffffff 1 3 3 0 3ffe085 0 00000000 0 0 00000000 0 0 00000108 0 0100 00000108
RESOLVE 00000104 ffffffff ffffffff 1 3 4 0 3ffe085 0 00000000 0 0 00000000 1 1 000000e4 0 1100 00000108
RESOLVE 00000104 ffffffff 00000000 1 3 5 0 3ffe085 0 00000000 0 0 00000000 0 0 00000108 0 0100 00000108
RESOLVE 00000104 7fffffff 80000000 1 3 6 0 3ffe085 0 00000000 0 0 00000000 1 1 000000e4 0 1100 00000108
RESOLVE 00000104 ffffffff 00000000 1 3 7 0 3ffe085 0 00000000 0 0 00000000 1 1 000000e4 0 1100 00000108
RESOLVE 00000200 00000000 00000000 1 1 0 0 3ff03ff 0 00000000 0 0 00000000 1 1 00000100 1 1000 00000204
RESOLVE 00000104 00000000 00000000 1 3 0 0 3ffe085 0 00000000 1 0 00000000 0 1 000000e4 0 1100 00000108
RESOLVE 00000300 00000000 00000000 1 0 0 0 0000000 0 00000000 0 1 00001c00 1 0 00001c00 0 0000 00000304
RESOLVE 00000104 00000000 00000000 1 3 0 0 3ffe085 0 00000000 1 1 00001c00 1 1 00001c00 0 1100 00000108

// ==== bpu_top.sv ====
/*
 * Branch prediction unit top. Fetch gets a prediction one cycle after
 * presenting its PC; execute gets the update bus in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module bpu_top import bpu_pkg::*; (
	input  logic         clk,
	input  logic         arst_n_i,
	input  logic         fetch_valid_i,
	input  logic [31:0]  fetch_pc_i,
	input  logic         resolve_valid_i,
	input  logic [31:0]  res_pc_i,
	input  logic [31:0]  rj_i,
	input  logic [31:0]  rd_i,
	input  decode_info_t decode_i,
	input  predict_t     res_predict_i,
	input  logic         stall_i,
	input  logic         csr_flush_i,
	input  logic [31:0]  csr_target_i,
	output logic         ready_o,
	output logic         predict_valid_o,
	output predict_t     predict_o,
	output update_t      update_o,
	output logic [31:0]  pc_link_o
);

	logic      lookup_en;
	btb_wr_t   btb_wr;
	bht_wr_t   bht_wr;
	logic      ras_push;
	logic      ras_pop;
	logic      btb_hit;
	waddr_t    btb_target;
	br_class_e btb_class;
	logic      bht_taken;
	waddr_t    ras_top;
	waddr_t    ras_top_q;
	waddr_t    fall_q;
	logic      pred_taken;

	bpu_ctrl u_ctrl (
		.clk, .arst_n_i, .resolve_valid_i, .stall_i, .csr_flush_i, .fetch_valid_i,
		.req_i(update_o), .ready_o, .lookup_en_o(lookup_en),
		.btb_wr_o(btb_wr), .bht_wr_o(bht_wr), .ras_push_o(ras_push), .ras_pop_o(ras_pop)
	);

	bpu_btb u_btb (
		.clk, .arst_n_i, .lookup_en_i(lookup_en), .lookup_pc_i(fetch_pc_i), .wr_i(btb_wr),
		.hit_o(btb_hit), .target_o(btb_target), .class_o(btb_class)
	);

	bpu_bht u_bht (
		.clk, .arst_n_i, .lookup_en_i(lookup_en), .lookup_pc_i(fetch_pc_i), .wr_i(bht_wr),
		.taken_o(bht_taken)
	);

	bpu_ras u_ras (
		.clk, .arst_n_i, .push_i(ras_push), .push_addr_i(pc_link_o[31:2]), .pop_i(ras_pop),
		.top_o(ras_top)
	);

	bpu_bpf u_bpf (
		.res_pc_i, .rj_i, .rd_i, .csr_target_i, .decode_i, .predict_i(res_predict_i),
		.stall_i, .csr_flush_i, .update_o, .pc_link_o
	);

	// --------------------
	// Prediction stage
	// --------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			predict_valid_o <= 1'b0;
		else
			predict_valid_o <= lookup_en;
	end

	// Stack top sampled with the tables
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			ras_top_q <= ras_top;
			fall_q    <= fetch_pc_i[31:2] + 1'b1;
		end
	end

	// Counter only matters for PC-relative branches
	assign pred_taken = btb_hit & ((btb_class != CLS_PCREL) | bht_taken);

	always_comb begin
		predict_o.taken = pred_taken;
		if (!pred_taken)
			predict_o.npc = fall_q;
		else if (btb_class == CLS_RET)
			predict_o.npc = ras_top_q;
		else
			predict_o.npc = btb_target;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
bpu_pkg.sv
bpu_ctrl.sv
bpu_btb.sv
bpu_bht.sv
bpu_ras.sv
bpu_bpf.sv
bpu_top.sv
bpu_properties.sv
tb_bpu.sv

// ==== tb_bpu.sv ====
/*
 * Testbench for the branch prediction unit. Replays the test data file one
 * resolve or fetch per line and checks the update bus, link and prediction.
 * Run from the project root so the data file is found.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_bpu import bpu_pkg::*; ();

	logic         clk = 1'b0;
	logic         arst_n_i;
	logic         fetch_valid_i;
	logic [31:0]  fetch_pc_i;
	logic         resolve_valid_i;
	logic [31:0]  res_pc_i;
	logic [31:0]  rj_i;
	logic [31:0]  rd_i;
	decode_info_t decode_i;
	predict_t     res_predict_i;
	logic         stall_i;
	logic         csr_flush_i;
	logic [31:0]  csr_target_i;
	logic         ready_o;
	logic         predict_valid_o;
	predict_t     predict_o;
	update_t      update_o;
	logic [31:0]  pc_link_o;

	string lines[$];
	logic  loaded = 1'b0;
	int    errors = 0;
	int    n_pass = 0;
	int    n_fail = 0;
	int    seed = 32'hd24a_f91e;

	bpu_top DUT (.*);

	always #2 clk = ~clk;

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_update(input string name, input update_t exp, input update_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_predict(input string name, input predict_t exp, input predict_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_link(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	// --------------------
	// Drivers
	// --------------------
	task automatic idle_resolve();
		resolve_valid_i = 1'b0;
		res_pc_i        = '0;
		rj_i            = '0;
		rd_i            = '0;
		decode_i        = '0;
		res_predict_i   = '0;
		stall_i         = 1'b0;
		csr_flush_i     = 1'b0;
		csr_target_i    = '0;
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic apply_resolve(input logic [31:0] pc, rj, rd, input decode_info_t dec,
		input predict_t pred, input logic stl, csf, input logic [31:0] csrt,
		input update_t exp_upd, input logic [31:0] exp_link);
		resolve_valid_i = 1'b1;
		res_pc_i        = pc;
		rj_i            = rj;
		rd_i            = rd;
		decode_i        = dec;
		res_predict_i   = pred;
		stall_i         = stl;
		csr_flush_i     = csf;
		csr_target_i    = csrt;
		@(negedge clk);
		check_update("update_o", exp_upd, update_o);
		check_link("pc_link_o", exp_link, pc_link_o);
		@(posedge clk);
		#1;
		idle_resolve();
	endtask

	task automatic apply_fetch(input logic [31:0] pc, input predict_t exp);
		fetch_valid_i = 1'b1;
		fetch_pc_i    = pc;
		@(posedge clk);
		#1;
		fetch_valid_i = 1'b0;
		// Prediction is held for the whole cycle after the lookup
		@(negedge clk);
		check_level("predict_valid_o", 1'b1, predict_valid_o);
		check_predict("predict_o", exp, predict_o);
		@(posedge clk);
		#1;
	endtask

	// --------------------
	// Test data
	// --------------------
	task automatic load_tests(output logic ok);
		int    fd;
		int    n;
		string line;
		fd = $fopen("bpu_testdata.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// Comments and blank lines dropped
				if (n > 1 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	task automatic run_line(input int num, input string line);
		logic [63:0]  op;
		logic [31:0]  pc, rj, rd, pnpc, csrt, etarget, elink, enpc;
		logic [1:0]   bt;
		logic [1:0]   ecls;
		logic [2:0]   cmp;
		logic [25:0]  inst;
		logic         vld, lnk, ptk, stl, csf, eflush, etaken;
		logic [3:0]   etrain;
		decode_info_t dec;
		predict_t     pred;
		predict_t     exp_pred;
		update_t      exp_upd;
		int           n;
		int           errs_at_start;
		string        kind;
		errs_at_start = errors;
		pc   = '0;
		kind = "unknown";
		n = $sscanf(line, "%s", op);
		if (op == 64'("RESOLVE")) begin
			kind = "RESOLVE";
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h",
				op, pc, rj, rd, vld, bt, cmp, lnk, inst, ptk, pnpc, stl, csf, csrt,
				eflush, etaken, etarget, ecls, etrain, elink);
			if (n != 20) begin
				$display("Line %0d of the test data could not be parsed", num);
				errors++;
			end else begin
				dec.valid          = vld;
				dec.branch_type    = branch_type_e'(bt);
				dec.cmp_type       = cmp_type_e'(cmp);
				dec.link           = lnk;
				dec.inst           = inst;
				pred.taken         = ptk;
				pred.npc           = pnpc[31:2];
				exp_upd.flush      = eflush;
				exp_upd.br_taken   = etaken;
				exp_upd.pc         = pc[31:2];
				exp_upd.br_target  = etarget;
				exp_upd.br_class   = br_class_e'(ecls);
				// Training bits in the order btb, bht, push, pop
				exp_upd.btb_we     = etrain[3];
				exp_upd.bht_we     = etrain[2];
				exp_upd.ras_push   = etrain[1];
				exp_upd.ras_pop    = etrain[0];
				apply_resolve(pc, rj, rd, dec, pred, stl, csf, csrt, exp_upd, elink);
			end
		end else if (op == 64'("FETCH")) begin
			kind = "FETCH";
			n = $sscanf(line, "%s %h %h %h", op, pc, etaken, enpc);
			if (n != 4) begin
				$display("Line %0d of the test data could not be parsed", num);
				errors++;
			end else begin
				exp_pred.taken = etaken;
				exp_pred.npc   = enpc[31:2];
				apply_fetch(pc, exp_pred);
			end
		end else begin
			$display("Line %0d of the test data has an unknown operation", num);
			errors++;
		end
		if (errors == errs_at_start) begin
			n_pass++;
			$display("Test %0d %s pc %h passed", num, kind, pc);
		end else begin
			n_fail++;
			$display("Test %0d %s pc %h failed", num, kind, pc);
		end
	endtask

	// Ready must follow reset release after exactly one sweep
	task automatic check_sweep();
		int cycles;
		cycles = 0;
		while (!ready_o) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (cycles == INIT_CYCLES) begin
			n_pass++;
			$display("Test 0 reset sweep passed");
		end else begin
			n_fail++;
			$display("ready_o rose %0d cycles after reset release instead of %0d",
				cycles, INIT_CYCLES);
			$display("Test 0 reset sweep failed");
		end
	endtask

	// --------------------
	// Sequencer
	// --------------------
	initial begin
		logic ok;
		int   gap;
		arst_n_i      = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pc_i    = '0;
		idle_resolve();
		load_tests(ok);
		loaded = 1'b1;
		if (!ok) begin
			$display("The test data file bpu_testdata.txt could not be opened");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (16) @(posedge clk);
			#1;
			arst_n_i = 1'b1;
			check_sweep();
			foreach (lines[i]) begin
				gap = {$random(seed)} % 2;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				run_line(i + 1, lines[i]);
			end
			$display("Summary: %0d tests, %0d passed, %0d failed",
				n_pass + n_fail, n_pass, n_fail);
			if (n_fail == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	// Reset, sweep and at most 4 cycles per test line
	initial begin : watchdog
		int unsigned limit;
		wait (loaded);
		limit = 16 + INIT_CYCLES + 4 * lines.size();
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
